/* Bender.yml */
package:
  name: rtc_bus_bridge

sources:
  - files:
      - src/rtcBusPkg.sv
      - src/rtcBusIf.sv
      - src/wbHostPort.sv
      - src/muxBusSequencer.sv
      - src/readCapture.sv
      - src/rtcBusBridge.sv
  - target: simulation
    files:
      - sim/tbClockGen.sv
      - sim/rtcModel.sv
      - sim/tbRtcBusBridge.sv

/* rtcBusBridge.f */
src/rtcBusPkg.sv
src/rtcBusIf.sv
src/wbHostPort.sv
src/muxBusSequencer.sv
src/readCapture.sv
src/rtcBusBridge.sv
sim/tbClockGen.sv
sim/rtcModel.sv
sim/tbRtcBusBridge.sv

/* sim/rtcModel.sv */
`timescale 1ns/1ps

module rtcModel import rtcBusPkg::*; #(
	parameter int asWidth = defAsWidth,
	parameter int dsWidth = defDsWidth,
	parameter realtime clkPeriod = 100.0
) (
	input logic asN,
	input logic csN,
	input logic rdN,
	input logic wrN,
	input dataT adOut,
	input logic adOe,
	output dataT adIn,
	output logic protoErr
);

	dataT regs [256];
	addrT lastAddr;
	int asCount;
	int wrCount;
	logic asLow;
	logic addrValid; // address latched, a data strobe may follow
	logic strobeLow;
	realtime asFall;
	realtime strobeFall;

	initial begin
		protoErr = 1'b0;
		asCount = 0;
		wrCount = 0;
		asLow = 1'b0;
		addrValid = 1'b0;
		strobeLow = 1'b0;
		lastAddr = '0;
		for (int i = 0; i < 256; i++)
			regs[i] = dataT'(i) ^ 8'h5a;
	end

	assign adIn = rdN ? '0 : regs[lastAddr]; // chip drives only while rdN is low

	task automatic violation(input string what);
		$display("rtcModel: %s at %0t ns", what, $time);
		protoErr = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// strobe order and widths
	////////////////////////////////////////////////////////////////////////////

	always @(negedge asN) begin
		if (addrValid || strobeLow)
			violation("address strobe while a transfer was still open");
		asLow = 1'b1;
		asFall = $realtime;
		asCount++;
	end

	always @(posedge asN) begin
		if (asLow) begin
			if ($realtime - asFall < asWidth * clkPeriod)
				violation("address strobe shorter than its minimum width");
			lastAddr = adOut; // address still on the bus in the hold cycle
			asLow = 1'b0;
			addrValid = 1'b1;
		end
	end

	task automatic startStrobe();
		if (!addrValid || asLow)
			violation("data strobe before a complete address phase");
		strobeLow = 1'b1;
		strobeFall = $realtime;
	endtask

	task automatic endStrobe();
		if ($realtime - strobeFall < dsWidth * clkPeriod)
			violation("data strobe shorter than its minimum width");
		strobeLow = 1'b0;
		addrValid = 1'b0;
	endtask

	always @(negedge rdN) startStrobe();
	always @(negedge wrN) startStrobe();

	always @(posedge rdN) begin
		if (strobeLow)
			endStrobe();
	end

	always @(posedge wrN) begin
		if (strobeLow) begin
			regs[lastAddr] = adOut; // bridge still holds the write data
			wrCount++;
			endStrobe();
		end
	end

	// pin levels settle a moment after each clock edge
	always @(csN or rdN or wrN or adOe) begin
		#1;
		if (!csN && rdN && wrN)
			violation("chip select low without a read or write strobe");
		if (csN && !(rdN && wrN))
			violation("read or write strobe without chip select");
		if (!rdN && adOe)
			violation("bridge drives the AD bus during a read strobe");
	end

endmodule

/* sim/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen #(
	parameter realtime period = 100.0,
	parameter int resetCycles = 8
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#5;
		rstN = 1'b1; // released just after a rising edge
	end

endmodule

/* sim/tbRtcBusBridge.sv */
`timescale 1ns/1ps

module tbRtcBusBridge import rtcBusPkg::*; ();

	localparam int ackTimeout = 50;

	logic clk;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	addrT wbAdr;
	dataT wbDatI;
	dataT wbDatO;
	logic wbAck;
	logic asN;
	logic csN;
	logic rdN;
	logic wrN;
	dataT adOut;
	logic adOe;
	dataT adIn;
	logic protoErr;
	logic [31:0] rngState;
	int ackCount = 0;

	tbClockGen #(.period(100.0), .resetCycles(8)) clkGen (.*);

	rtcBusBridge i_dut (.*);

	rtcModel #(.asWidth(defAsWidth), .dsWidth(defDsWidth), .clkPeriod(100.0)) chip (.*);

	always @(negedge clk) begin
		if (rstN && wbAck)
			ackCount++;
	end

	always @(posedge protoErr)
		failNow("chip model reported a bus protocol violation");

	////////////////////////////////////////////////////////////////////////////
	// helpers and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic failNow(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkData(input string testName, input dataT expected, input dataT actual);
		if (actual !== expected)
			failNow($sformatf("CHECK FAILED %s: expected %02h, actual %02h",
				testName, expected, actual));
	endtask

	task automatic checkAddr(input string testName, input addrT expected, input addrT actual);
		if (actual !== expected)
			failNow($sformatf("CHECK FAILED %s: expected %02h, actual %02h",
				testName, expected, actual));
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected)
			failNow($sformatf("CHECK FAILED %s: expected %b, actual %b",
				testName, expected, actual));
	endtask

	task automatic checkCount(input string testName, input int expected, input int actual);
		if (actual !== expected)
			failNow($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	task automatic checkIdlePins(input string testName);
		checkFlag({testName, " asN"}, 1'b1, asN);
		checkFlag({testName, " csN"}, 1'b1, csN);
		checkFlag({testName, " rdN"}, 1'b1, rdN);
		checkFlag({testName, " wrN"}, 1'b1, wrN);
		checkFlag({testName, " adOe"}, 1'b0, adOe);
		checkFlag({testName, " wbAck"}, 1'b0, wbAck);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// entered and left 5 ns after a rising edge
	task automatic wbTransfer(input string testName, input logic we, input addrT adr,
			input dataT dat, input bit keepStb, output dataT rdat);
		int waited;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatI = dat;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wbAck && waited < ackTimeout);
		if (!wbAck)
			failNow($sformatf("%s: no wbAck within %0d cycles", testName, ackTimeout));
		rdat = wbDatO;
		@(posedge clk);
		#5;
		if (!keepStb) begin
			wbCyc = 1'b0;
			wbStb = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testReset();
		int waited;
		waited = 0;
		@(posedge clk);
		@(negedge clk);
		checkIdlePins("reset held");
		while (!rstN && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (!rstN)
			failNow("reset was never released");
		checkIdlePins("reset released");
		@(posedge clk);
		#5;
	endtask

	task automatic testSingleWrite();
		dataT rdat;
		wbTransfer("single write", 1'b1, 8'h3c, 8'ha5, 1'b0, rdat);
		checkData("single write", 8'ha5, chip.regs[8'h3c]);
		checkAddr("single write", 8'h3c, chip.lastAddr);
	endtask

	task automatic testWriteReadBack();
		dataT shadow [256]; // last byte written per address
		addrT adrList [8];
		dataT dat;
		dataT rdat;
		for (int i = 0; i < 8; i++) begin
			rngState = xorshift(rngState);
			adrList[i] = rngState[7:0];
			dat = rngState[15:8];
			wbTransfer("write then read", 1'b1, adrList[i], dat, 1'b0, rdat);
			shadow[adrList[i]] = dat;
		end
		for (int i = 0; i < 8; i++) begin
			wbTransfer("write then read", 1'b0, adrList[i], 8'h00, 1'b0, rdat);
			checkData("write then read", shadow[adrList[i]], rdat);
			checkAddr("write then read", adrList[i], chip.lastAddr);
		end
	endtask

	task automatic testPinTiming();
		int asStart;
		int wrStart;
		dataT dat;
		dataT rdat;
		asStart = chip.asCount;
		wrStart = chip.wrCount;
		rngState = xorshift(rngState);
		dat = rngState[7:0];
		wbTransfer("pin timing", 1'b1, 8'hff, dat, 1'b0, rdat);
		wbTransfer("pin timing", 1'b0, 8'hff, 8'h00, 1'b0, rdat);
		checkData("pin timing read", dat, rdat);
		checkCount("pin timing strobes", asStart + 2, chip.asCount);
		checkCount("pin timing writes", wrStart + 1, chip.wrCount);
		checkIdlePins("pin timing idle");
	endtask

	task automatic testBackToBack();
		int asStart;
		int ackStart;
		dataT rdat;
		asStart = chip.asCount;
		ackStart = ackCount;
		wbTransfer("back to back", 1'b1, 8'h10, 8'h77, 1'b1, rdat);
		// second request is only accepted after this ack
		checkCount("back to back first", asStart + 1, chip.asCount);
		wbTransfer("back to back", 1'b0, 8'h10, 8'h00, 1'b0, rdat);
		checkData("back to back read", 8'h77, rdat);
		checkCount("back to back strobes", asStart + 2, chip.asCount);
		checkCount("back to back acks", ackStart + 2, ackCount);
	endtask

	task automatic testAbandon();
		int ackStart;
		int wrStart;
		dataT rdat;
		ackStart = ackCount;
		wrStart = chip.wrCount;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = 8'hc3;
		wbDatI = 8'h5e;
		@(posedge clk);
		#5;
		wbCyc = 1'b0; // dropped right after the bridge took the request
		wbStb = 1'b0;
		@(posedge clk);
		#5;
		wbCyc = 1'b1; // a new cycle opens while the old transfer still runs, strobe low
		for (int i = 0; i < ackTimeout; i++) begin
			@(negedge clk);
			if (wbAck)
				failNow("abandoned cycle: wbAck appeared after the master dropped cyc");
		end
		checkData("abandoned cycle", 8'h5e, chip.regs[8'hc3]);
		checkAddr("abandoned cycle", 8'hc3, chip.lastAddr);
		checkCount("abandoned cycle writes", wrStart + 1, chip.wrCount);
		checkCount("abandoned cycle acks", ackStart, ackCount);
		@(posedge clk);
		#5;
		wbTransfer("after abandon", 1'b0, 8'hc3, 8'h00, 1'b0, rdat);
		checkData("after abandon", 8'h5e, rdat);
	endtask

	initial begin
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatI = '0;
		rngState = 32'h4604;
		testReset();
		testSingleWrite();
		testWriteReadBack();
		testPinTiming();
		testBackToBack();
		testAbandon();
		$display("** PASS **");
		$finish;
	end

endmodule

/* src/muxBusSequencer.sv */
`timescale 1ns/1ps

module muxBusSequencer import rtcBusPkg::*; #(
	parameter phaseCntT asWidth = defAsWidth,
	parameter phaseCntT gapCycles = defGapCycles,
	parameter phaseCntT dsWidth = defDsWidth,
	parameter phaseCntT recoveryCycles = defRecoveryCycles
) (
	input logic clk,
	input logic rstN,
	rtcBusIf.seq bus,
	output logic asN,
	output logic csN,
	output logic rdN,
	output logic wrN,
	output dataT adOut,
	output logic adOe
);

	seqStateT state;
	seqStateT nextState;
	phaseCntT phaseCnt;
	phaseCntT phaseLen;
	logic lastCycle;
	logic addrDrive;
	logic dataDrive;

	////////////////////////////////////////////////////////////////////////////
	// phase timing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			addrPhase: phaseLen = asWidth;
			turnPhase: phaseLen = gapCycles;
			strobePhase: phaseLen = dsWidth;
			recoverPhase: phaseLen = recoveryCycles;
			default: phaseLen = 5'd1; // addrHold and donePhase are single cycles
		endcase
	end

	assign lastCycle = (phaseCnt == phaseLen - 5'd1);

	always_comb begin
		nextState = state;
		case (state)
			idle: if (bus.req) nextState = addrPhase;
			addrPhase: if (lastCycle) nextState = addrHold;
			addrHold: nextState = turnPhase;
			turnPhase: if (lastCycle) nextState = strobePhase;
			strobePhase: if (lastCycle) nextState = recoverPhase;
			recoverPhase: if (lastCycle) nextState = donePhase;
			donePhase: nextState = idle;
			default: nextState = idle;
		endcase
	end

	// bus ownership for the coming cycle
	assign addrDrive = (nextState == addrPhase) || (nextState == addrHold);
	assign dataDrive = bus.write && ((nextState == turnPhase) || (nextState == strobePhase));

	////////////////////////////////////////////////////////////////////////////
	// state, counter and pins
	////////////////////////////////////////////////////////////////////////////

	// pins are decoded from nextState so they line up with state, glitch free
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			phaseCnt <= '0;
			asN <= 1'b1;
			csN <= 1'b1;
			rdN <= 1'b1;
			wrN <= 1'b1;
			adOe <= 1'b0;
		end else begin
			state <= nextState;
			if (nextState != state || state == idle)
				phaseCnt <= '0; // restart on every phase change
			else
				phaseCnt <= phaseCnt + 5'd1;
			asN <= (nextState != addrPhase);
			csN <= (nextState != strobePhase);
			rdN <= !(nextState == strobePhase && !bus.write);
			wrN <= !(nextState == strobePhase && bus.write);
			adOe <= addrDrive || dataDrive;
		end
	end

	always_ff @(posedge clk) begin
		if (addrDrive)
			adOut <= bus.addr;
		else if (dataDrive)
			adOut <= bus.wdata; // held through the strobe
	end

	assign bus.done = (state == donePhase);
	// rdN rises on the same edge, so the sample sees the chip still driving
	assign bus.rdSample = (state == strobePhase) && lastCycle && !bus.write;

	////////////////////////////////////////////////////////////////////////////
	// pin rules
	////////////////////////////////////////////////////////////////////////////

	rdWrExclusive: assert property (
		@(posedge clk) disable iff (!rstN)
		!(!rdN && !wrN)
	) else $error("rdN and wrN low together");

	csOnlyInStrobe: assert property (
		@(posedge clk) disable iff (!rstN)
		!csN |-> state == strobePhase && (!rdN || !wrN)
	) else $error("csN low outside the strobe phase");

	noDriveOnRead: assert property (
		@(posedge clk) disable iff (!rstN)
		!rdN |-> !adOe
	) else $error("AD bus driven during a read strobe");

endmodule

/* src/readCapture.sv */
`timescale 1ns/1ps

module readCapture import rtcBusPkg::*; (
	input logic clk,
	input logic rstN,
	rtcBusIf.capture bus,
	input dataT adIn,
	input logic wbCyc,
	output dataT wbDatO,
	output logic wbAck
);

	dataT rdData;

	// held until the next read strobe ends
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			rdData <= '0;
		else if (bus.rdSample)
			rdData <= adIn;
	end

	// data is only valid alongside done
	assign wbDatO = bus.done ? rdData : '0;

	// an abandoned cycle finishes on the chip side without an ack
	assign wbAck = bus.done && !bus.abort && wbCyc;

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	singleAck: assert property (
		@(posedge clk) disable iff (!rstN)
		wbAck |=> !wbAck
	) else $error("wbAck held for two cycles");

	// a read sample always belongs to a transfer that then completes
	sampleBeforeDone: assert property (
		@(posedge clk) disable iff (!rstN)
		bus.rdSample |-> ##[1:40] bus.done
	) else $error("read sampled but transfer never completed");

endmodule

/* src/rtcBusBridge.sv */
`timescale 1ns/1ps

module rtcBusBridge import rtcBusPkg::*; #(
	parameter phaseCntT asWidth = defAsWidth,
	parameter phaseCntT gapCycles = defGapCycles,
	parameter phaseCntT dsWidth = defDsWidth,
	parameter phaseCntT recoveryCycles = defRecoveryCycles
) (
	input logic clk,
	input logic rstN,

	// Wishbone classic slave
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input addrT wbAdr,
	input dataT wbDatI,
	output dataT wbDatO,
	output logic wbAck,

	// multiplexed AD peripheral bus
	output logic asN,
	output logic csN,
	output logic rdN,
	output logic wrN,
	output dataT adOut,
	output logic adOe,
	input dataT adIn
);

	rtcBusIf bus ();

	wbHostPort hostPort (
		.clk    (clk),
		.rstN   (rstN),
		.wbCyc  (wbCyc),
		.wbStb  (wbStb),
		.wbWe   (wbWe),
		.wbAdr  (wbAdr),
		.wbDatI (wbDatI),
		.bus    (bus.host)
	);

	muxBusSequencer #(
		.asWidth        (asWidth),
		.gapCycles      (gapCycles),
		.dsWidth        (dsWidth),
		.recoveryCycles (recoveryCycles)
	) sequencer (
		.clk   (clk),
		.rstN  (rstN),
		.bus   (bus.seq),
		.asN   (asN),
		.csN   (csN),
		.rdN   (rdN),
		.wrN   (wrN),
		.adOut (adOut),
		.adOe  (adOe)
	);

	readCapture capture (
		.clk    (clk),
		.rstN   (rstN),
		.bus    (bus.capture),
		.adIn   (adIn),
		.wbCyc  (wbCyc),
		.wbDatO (wbDatO),
		.wbAck  (wbAck)
	);

endmodule

/* src/rtcBusIf.sv */
`timescale 1ns/1ps

interface rtcBusIf import rtcBusPkg::*; ();

	// request side, held by the host port until done
	logic req;
	logic write;
	addrT addr;
	dataT wdata;
	logic abort; // master dropped cyc during the transfer

	// completion side
	logic done;     // one cycle in donePhase
	logic rdSample; // last strobe cycle of a read

	modport host (
		output req, write, addr, wdata, abort,
		input done
	);

	modport seq (
		input req, write, addr, wdata,
		output done, rdSample
	);

	modport capture (
		input rdSample, done, abort
	);

endinterface

/* src/rtcBusPkg.sv */
package rtcBusPkg;

	////////////////////////////////////////////////////////////////////////////
	// peripheral bus payload
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0] addrT; // register address on the AD bus
	typedef logic [7:0] dataT; // data byte on the AD bus

	////////////////////////////////////////////////////////////////////////////
	// sequencer timing
	////////////////////////////////////////////////////////////////////////////

	typedef logic [4:0] phaseCntT; // up to 31 cycles per phase

	typedef enum logic [2:0] {
		idle,         // waiting for a request
		addrPhase,    // asN low, address on the bus
		addrHold,     // asN back high, address still driven
		turnPhase,    // write data set up or bus released for a read
		strobePhase,  // csN and rdN or wrN low
		recoverPhase, // strobes high, bus released
		donePhase     // done pulse back to the host side
	} seqStateT;

	// default phase lengths in clk cycles, each at least 1
	parameter phaseCntT defAsWidth = 5'd2;
	parameter phaseCntT defGapCycles = 5'd2;
	parameter phaseCntT defDsWidth = 5'd4;
	parameter phaseCntT defRecoveryCycles = 5'd2;

endpackage

/* src/wbHostPort.sv */
`timescale 1ns/1ps

module wbHostPort import rtcBusPkg::*; (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input addrT wbAdr,
	input dataT wbDatI,
	rtcBusIf.host bus
);

	logic accept;
	logic abandon;

	// one transfer in flight, a new strobe waits until req drops
	assign accept = !bus.req && wbCyc && wbStb;
	assign abandon = bus.req && !wbCyc;

	////////////////////////////////////////////////////////////////////////////
	// request holding
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bus.req <= 1'b0;
		end else if (accept) begin
			bus.req <= 1'b1;
		end else if (bus.done) begin
			bus.req <= 1'b0; // back to idle after the sequencer finishes
		end
	end

	// the transfer completes anyway, only its ack is dropped
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bus.abort <= 1'b0;
		end else if (accept) begin
			bus.abort <= 1'b0; // fresh cycle
		end else if (abandon) begin
			bus.abort <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			bus.addr <= wbAdr;
			bus.wdata <= wbDatI;
			bus.write <= wbWe;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// request fields must not move under the sequencer until it reports done
	reqStable: assert property (
		@(posedge clk) disable iff (!rstN)
		bus.req && !bus.done |=> $stable(bus.addr) && $stable(bus.write) && $stable(bus.wdata)
	) else $error("request fields changed before done");

endmodule
